// File: backend_config.svh
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

////////////////////
// Datapath sizing
////////////////////

`define XLEN        32
`define PRF_DEPTH   32
`define IMM_WIDTH   17

// Lane 0 is the ALU, lane 1 the multiplier
`define CDB_WIDTH   2
`define MUL_LATENCY 3

`endif

// File: backend_pkg.sv
`include "backend_config.svh"

package backend_pkg;

    typedef logic [`XLEN-1:0]              word_t;
    typedef logic [$clog2(`PRF_DEPTH)-1:0] phy_t;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_MUL
    } op_t;

    ////////////////////
    // Operand word, decoded by use_imm
    ////////////////////

    typedef struct packed {
        phy_t                              rs1;
        phy_t                              rs2;
        logic [`IMM_WIDTH-$bits(phy_t)-1:0] pad;
    } operands_rr_t;

    typedef struct packed {
        phy_t                    rs1;
        logic [`IMM_WIDTH-1:0]   imm;     // Two's complement
    } operands_ri_t;

    typedef union packed {
        operands_rr_t rr;
        operands_ri_t ri;
    } operands_u;

    typedef struct packed {
        logic      valid;
        op_t       op;
        logic      use_imm;
        phy_t      rd;
        operands_u operands;
    } issue_req_t;

    typedef struct packed {
        phy_t rs1_phy;
        phy_t rs2_phy;
    } prf_rd_req_t;

    typedef struct packed {
        word_t rs1_value;
        word_t rs2_value;
    } prf_rd_rsp_t;

    typedef struct packed {
        logic  valid;
        op_t   op;
        phy_t  rd;
        word_t src_a;
        word_t src_b;
    } exec_req_t;

    typedef struct packed {
        logic  valid;
        phy_t  rd_phy;
        word_t rd_value;
    } cdb_t;

endpackage

// File: prf.sv
`include "backend_config.svh"

module prf
    import backend_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  prf_rd_req_t rd_req,
    output prf_rd_rsp_t rd_rsp,

    input  cdb_t        cdb [`CDB_WIDTH]
);

    localparam int NUM_PORTS = 2;

    word_t mem [`PRF_DEPTH-1:1];   // Register 0 has no storage

    phy_t                  src_phy [NUM_PORTS];
    word_t                 src_val [NUM_PORTS];
    logic [`CDB_WIDTH-1:0] hit     [NUM_PORTS];

    ////////////////////
    // Writeback
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `PRF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int j = 0; j < `CDB_WIDTH; j++) begin
                if (cdb[j].valid && (cdb[j].rd_phy != '0)) begin
                    mem[cdb[j].rd_phy] <= cdb[j].rd_value;
                end
            end
        end
    end

    ////////////////////
    // Read with lane bypass
    ////////////////////

    assign src_phy[0] = rd_req.rs1_phy;
    assign src_phy[1] = rd_req.rs2_phy;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        for (genvar j = 0; j < `CDB_WIDTH; j++) begin : g_lane
            assign hit[p][j] = cdb[j].valid && (cdb[j].rd_phy != '0) &&
                               (cdb[j].rd_phy == src_phy[p]);
        end

        // Two lanes on one register would mean the busy check let a WAW through
        a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(hit[p]))
            else $error("prf: port %0d matches more than one lane", p);
    end

    always_comb begin
        word_t stored;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (src_phy[p] == '0) begin
                stored = '0;
            end else begin
                stored = mem[src_phy[p]];
            end
            src_val[p] = stored;
            for (int j = 0; j < `CDB_WIDTH; j++) begin
                if (hit[p][j]) begin
                    src_val[p] = cdb[j].rd_value;   // At most one lane hits
                end
            end
        end
    end

    assign rd_rsp.rs1_value = src_val[0];
    assign rd_rsp.rs2_value = src_val[1];

endmodule

// File: issue_ctrl.sv
`include "backend_config.svh"

module issue_ctrl
    import backend_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  issue_req_t  issue,
    output logic        issue_stall,

    output prf_rd_req_t rd_req,
    input  prf_rd_rsp_t rd_rsp,

    input  cdb_t        cdb [`CDB_WIDTH],

    output exec_req_t   alu_req,
    output exec_req_t   mul_req
);

    logic [`PRF_DEPTH-1:0] busy;
    logic [`PRF_DEPTH-1:0] busy_nxt;
    logic [`PRF_DEPTH-1:0] bcast;
    logic [`PRF_DEPTH-1:0] pend;

    phy_t  rs1;
    phy_t  rs2;
    word_t imm_ext;
    logic  accept;
    logic  is_mul;

    logic  alu_valid_q;
    logic  mul_valid_q;
    op_t   op_q;
    phy_t  rd_q;
    word_t src_a_q;
    word_t src_b_q;

    ////////////////////
    // Scoreboard and stall
    ////////////////////

    always_comb begin
        bcast = '0;
        for (int j = 0; j < `CDB_WIDTH; j++) begin
            if (cdb[j].valid) begin
                bcast[cdb[j].rd_phy] = 1'b1;
            end
        end
    end

    assign pend = busy & ~bcast;   // Broadcast this cycle counts as ready

    assign rs1 = issue.operands.rr.rs1;   // Same bits in the ri view
    assign rs2 = issue.operands.rr.rs2;

    assign issue_stall = issue.valid &&
                         (pend[rs1] || (!issue.use_imm && pend[rs2]) || pend[issue.rd]);
    assign accept      = issue.valid && !issue_stall;

    always_comb begin
        busy_nxt = busy & ~bcast;
        if (accept && (issue.rd != '0)) begin
            busy_nxt[issue.rd] = 1'b1;   // New owner wins over a clearing broadcast
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= busy_nxt;
        end
    end

    ////////////////////
    // Operand read and dispatch
    ////////////////////

    assign rd_req.rs1_phy = rs1;
    assign rd_req.rs2_phy = issue.use_imm ? phy_t'(0) : rs2;

    assign imm_ext = {{(`XLEN-`IMM_WIDTH){issue.operands.ri.imm[`IMM_WIDTH-1]}},
                      issue.operands.ri.imm};

    assign is_mul = (issue.op == OP_MUL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_valid_q <= 1'b0;
            mul_valid_q <= 1'b0;
        end else begin
            alu_valid_q <= accept && !is_mul;
            mul_valid_q <= accept && is_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= issue.op;
            rd_q    <= issue.rd;
            src_a_q <= rd_rsp.rs1_value;
            src_b_q <= issue.use_imm ? imm_ext : rd_rsp.rs2_value;
        end
    end

    assign alu_req = '{valid: alu_valid_q, op: op_q, rd: rd_q, src_a: src_a_q, src_b: src_b_q};
    assign mul_req = '{valid: mul_valid_q, op: op_q, rd: rd_q, src_a: src_a_q, src_b: src_b_q};

    a_stall_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        issue_stall |-> issue.valid)
        else $error("issue_ctrl: stall without a valid issue");

    a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_req.valid && mul_req.valid))
        else $error("issue_ctrl: both units requested");

    a_rd_free: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && (issue.rd != '0)) |-> !pend[issue.rd])
        else $error("issue_ctrl: accepted rd %0d still pending", issue.rd);

endmodule

// File: alu_unit.sv
module alu_unit
    import backend_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  exec_req_t req,
    output cdb_t      result
);

    localparam int SHAMT_W = $clog2($bits(word_t));

    logic [SHAMT_W-1:0] shamt;
    word_t              res;

    logic  valid_q;
    phy_t  rd_q;
    word_t value_q;

    assign shamt = req.src_b[SHAMT_W-1:0];

    always_comb begin
        case (req.op)
            OP_ADD:  res = req.src_a + req.src_b;
            OP_SUB:  res = req.src_a - req.src_b;
            OP_AND:  res = req.src_a & req.src_b;
            OP_OR:   res = req.src_a | req.src_b;
            OP_XOR:  res = req.src_a ^ req.src_b;
            OP_SLL:  res = req.src_a << shamt;
            OP_SRL:  res = req.src_a >> shamt;   // Logical
            default: res = '0;                   // MUL goes to the multiplier
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        rd_q    <= req.rd;
        value_q <= res;
    end

    assign result = '{valid: valid_q, rd_phy: rd_q, rd_value: value_q};

endmodule

// File: mul_unit.sv
`include "backend_config.svh"

module mul_unit
    import backend_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  exec_req_t req,
    output cdb_t      result
);

    localparam int HALF = `XLEN / 2;
    localparam int LAST = `MUL_LATENCY - 1;

    logic [LAST:0]   vld_q;
    phy_t            rd_q   [`MUL_LATENCY];
    word_t           prod_q [`MUL_LATENCY];
    logic [HALF-1:0] cross_q;   // a_lo * b_hi, only its low half reaches the result

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LAST-1:0], req.valid};
        end
    end

    ////////////////////
    // Split low-half product
    ////////////////////

    always_ff @(posedge clk) begin
        rd_q[0]   <= req.rd;
        prod_q[0] <= req.src_a * req.src_b[HALF-1:0];
        cross_q   <= req.src_a[HALF-1:0] * req.src_b[`XLEN-1:HALF];

        rd_q[1]   <= rd_q[0];
        prod_q[1] <= prod_q[0] + {cross_q, {HALF{1'b0}}};

        for (int k = 2; k < `MUL_LATENCY; k++) begin
            rd_q[k]   <= rd_q[k-1];
            prod_q[k] <= prod_q[k-1];
        end
    end

    assign result = '{valid: vld_q[LAST], rd_phy: rd_q[LAST], rd_value: prod_q[LAST]};

    // Dispatch must only route MUL here
    a_mul_only: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> (req.op == OP_MUL))
        else $error("mul_unit: non-MUL op %0d dispatched", req.op);

endmodule

// File: exec_backend.sv
`include "backend_config.svh"

module exec_backend (
    input  logic                    clk,
    input  logic                    rst_n,

    input  backend_pkg::issue_req_t issue,
    output logic                    issue_stall,

    output backend_pkg::cdb_t       cdb [`CDB_WIDTH]
);

    backend_pkg::prf_rd_req_t rd_req;
    backend_pkg::prf_rd_rsp_t rd_rsp;
    backend_pkg::exec_req_t   alu_req;
    backend_pkg::exec_req_t   mul_req;

    ////////////////////
    // Control and register file
    ////////////////////

    issue_ctrl issue_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .issue_stall (issue_stall),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp),
        .cdb         (cdb),
        .alu_req     (alu_req),
        .mul_req     (mul_req)
    );

    prf prf_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp),
        .cdb    (cdb)
    );

    ////////////////////
    // Execution units
    ////////////////////

    alu_unit alu_unit_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (alu_req),
        .result (cdb[0])   // Lane 0
    );

    mul_unit mul_unit_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (mul_req),
        .result (cdb[1])   // Lane 1
    );

endmodule

// File: tb_exec_backend.sv
`include "backend_config.svh"

module tb_exec_backend
    import backend_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD    = 10;
    localparam int ALU_EDGES = 2;
    localparam int MUL_EDGES = 1 + `MUL_LATENCY;
    localparam int N_RANDOM  = 380;
    localparam int LIMIT     = 400 * 6 + 100;

    typedef struct packed {
        logic [63:0] at;      // Acceptance time
        phy_t        rd;
        word_t       value;
    } exp_t;

    logic       clk;
    logic       rst_n;
    issue_req_t issue;
    logic       issue_stall;
    cdb_t       cdb [`CDB_WIDTH];

    word_t       model [`PRF_DEPTH];
    exp_t        exp_q [`CDB_WIDTH][$];
    logic [31:0] lcg_state = 32'd4;
    int          cycles = 0;

    exec_backend exec_backend_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .issue_stall (issue_stall),
        .cdb         (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic int unsigned rand_below(int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % n;
    endfunction

    function automatic word_t ref_result(op_t op, word_t a, word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            default: return a * b;   // Low half of the product
        endcase
    endfunction

    function automatic issue_req_t make_req(op_t op, logic use_imm, phy_t rd, phy_t rs1,
                                            phy_t rs2, logic [`IMM_WIDTH-1:0] imm);
        issue_req_t req;
        req = '0;
        req.valid   = 1'b1;
        req.op      = op;
        req.use_imm = use_imm;
        req.rd      = rd;
        if (use_imm) begin
            req.operands.ri.rs1 = rs1;
            req.operands.ri.imm = imm;
        end else begin
            req.operands.rr.rs1 = rs1;
            req.operands.rr.rs2 = rs2;
        end
        return req;
    endfunction

    task automatic check_equal(string what, logic [63:0] got, logic [63:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, what, got, expected);
            $display("TEST FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic abort_run(string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    // Reference model update at acceptance
    task automatic model_accept(issue_req_t req);
        word_t a;
        word_t b;
        exp_t  e;
        if (req.use_imm) begin
            a = model[req.operands.ri.rs1];
            b = $signed(req.operands.ri.imm);
        end else begin
            a = model[req.operands.rr.rs1];
            b = model[req.operands.rr.rs2];
        end
        e = '{at: $time, rd: req.rd, value: ref_result(req.op, a, b)};
        if (req.op == OP_MUL) begin
            exp_q[1].push_back(e);
        end else begin
            exp_q[0].push_back(e);
        end
        if (req.rd != '0) begin
            model[req.rd] = e.value;
        end
    endtask

    task automatic send(issue_req_t req, output logic [63:0] at);
        issue <= req;
        do @(posedge clk); while (issue_stall);   // Held while stalled
        at = $time;
        model_accept(req);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        logic [63:0]          t_a;
        logic [63:0]          t_b;
        logic [`IMM_WIDTH-1:0] imm;
        op_t                  op;
        rst_n = 1'b0;
        issue = '0;
        for (int i = 0; i < `PRF_DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_equal("issue_stall with no issue", issue_stall, 1'b0);
        end
        for (int r = 1; r < 8; r++) begin
            send(make_req(OP_ADD, 1'b1, phy_t'(r), phy_t'(r), '0, '0), t_a);   // Reads reset 0
        end
        send(make_req(OP_ADD, 1'b1, 1, 0, 0, 17'd1234), t_a);
        send(make_req(OP_ADD, 1'b1, 2, 0, 0, -17'sd7), t_a);
        send(make_req(OP_MUL, 1'b0, 3, 1, 2, '0), t_a);
        send(make_req(OP_ADD, 1'b1, 4, 3, 0, 17'd1), t_b);
        check_equal("edges from MUL to dependent accept", (t_b - t_a) / PERIOD, MUL_EDGES);
        send(make_req(OP_SUB, 1'b0, 5, 1, 4, '0), t_a);
        send(make_req(OP_XOR, 1'b1, 6, 5, 0, 17'h1_0f0f), t_b);
        check_equal("edges from ALU to dependent accept", (t_b - t_a) / PERIOD, ALU_EDGES);
        send(make_req(OP_OR, 1'b0, 0, 6, 5, '0), t_a);   // Write to register 0
        issue <= '0;
        @(posedge clk);
        send(make_req(OP_ADD, 1'b1, 7, 0, 0, '0), t_a);   // Lane 0 carries rd 0 here
        for (int n = 0; n < N_RANDOM; n++) begin
            op  = op_t'(rand_below(8));
            imm = rand_below(1 << `IMM_WIDTH);
            send(make_req(op, rand_below(2) == 1, phy_t'(rand_below(6)), phy_t'(rand_below(6)),
                          phy_t'(rand_below(6)), imm), t_a);
            if (rand_below(8) == 0) begin
                issue <= '0;
                @(posedge clk);
                check_equal("issue_stall with no issue", issue_stall, 1'b0);
            end
        end
        issue <= '0;
        repeat (MUL_EDGES + 2) @(posedge clk);   // Longest lane latency plus margin
        @(negedge clk);
        if (exp_q[0].size() + exp_q[1].size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("ERROR: %0d accepted instructions never broadcast",
                     exp_q[0].size() + exp_q[1].size());
            $display("TEST FAIL");
            $fatal(1, "expectations left over");
        end
    end

    ////////////////////
    // Lane comparison
    ////////////////////

    always @(posedge clk) begin : compare
        exp_t e;
        int   edges;
        if (rst_n) begin
            for (int j = 0; j < `CDB_WIDTH; j++) begin
                edges = (j == 0) ? ALU_EDGES : MUL_EDGES;
                if (cdb[j].valid) begin
                    if (exp_q[j].size() == 0) begin
                        abort_run($sformatf("lane %0d broadcast with nothing in flight", j));
                    end else begin
                        e = exp_q[j].pop_front();
                        check_equal($sformatf("lane %0d edges after accept", j),
                                    ($time - e.at) / PERIOD, edges);
                        check_equal($sformatf("lane %0d rd", j), cdb[j].rd_phy, e.rd);
                        check_equal($sformatf("lane %0d value", j), cdb[j].rd_value, e.value);
                    end
                end else if (exp_q[j].size() != 0 &&
                             $time >= exp_q[j][0].at + edges * PERIOD) begin
                    abort_run($sformatf("lane %0d missed a broadcast for rd %0d",
                                        j, exp_q[j][0].rd));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles", cycles));
        end
    end

endmodule

// File: flist.f
+incdir+.
backend_pkg.sv
prf.sv
issue_ctrl.sv
alu_unit.sv
mul_unit.sv
exec_backend.sv
tb_exec_backend.sv
